/* source/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

    localparam int XLEN  = 32;
    localparam int SEL_W = XLEN / 8;

    // access size, funct3 encoding of loads and stores
    typedef enum logic [2:0]
    {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    // one bus user towards the arbiter
    typedef struct packed
    {
        logic [XLEN-1:0]  adr;
        logic [XLEN-1:0]  dat;
        logic             we;
        logic [SEL_W-1:0] sel;
    } bus_req_t;

    typedef struct packed
    {
        logic             valid;
        logic [XLEN-1:2]  pc;      // word address
        logic [XLEN-1:0]  word;
    } fetch_t;

    // data access from the core, store data not yet aligned
    typedef struct packed
    {
        logic             read;
        logic             write;
        mem_size_e        size;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  wdata;
    } mem_req_t;

    typedef struct packed
    {
        logic             valid;
        logic [XLEN-1:0]  data;
    } load_t;

endpackage

`default_nettype wire

/* source/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter logic [rv_bus_pkg::XLEN-1:0] RESET_ADDR = '0
)
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_redirect,
    input  logic [rv_bus_pkg::XLEN-1:0] i_redirect_pc,
    input  logic                        i_ack,
    input  logic [rv_bus_pkg::XLEN-1:0] i_data,
    output rv_bus_pkg::bus_req_t        o_req,
    output rv_bus_pkg::fetch_t          o_instr
);

    import rv_bus_pkg::*;

    logic [XLEN-1:0] r_pc;
    logic            r_valid;
    logic [XLEN-1:2] r_instr_pc;
    logic [XLEN-1:0] r_instr_word;

    // program counter, holds until acknowledged
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_pc <= RESET_ADDR;
        end
        else if (i_redirect)
        begin
            r_pc <= i_redirect_pc;
        end
        else if (i_ack)
        begin
            r_pc <= r_pc + XLEN'(4);
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_valid <= 1'b0;
        end
        else
        begin
            r_valid <= i_ack & ~i_redirect;   // redirect drops the word in flight
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ack)
        begin
            r_instr_pc   <= r_pc[XLEN-1:2];
            r_instr_word <= i_data;
        end
    end

    // always a full word read
    assign o_req.adr = r_pc;
    assign o_req.dat = '0;
    assign o_req.we  = 1'b0;
    assign o_req.sel = '1;

    assign o_instr.valid = r_valid;
    assign o_instr.pc    = r_instr_pc;
    assign o_instr.word  = r_instr_word;

endmodule

`default_nettype wire

/* source/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  rv_bus_pkg::mem_req_t        i_mem_req,
    input  logic                        i_ack,
    input  logic [rv_bus_pkg::XLEN-1:0] i_data,
    output rv_bus_pkg::bus_req_t        o_req,
    output logic                        o_active,
    output rv_bus_pkg::load_t           o_load
);

    import rv_bus_pkg::*;

    mem_req_t         r_req;
    logic             r_active;
    logic             r_load_valid;
    logic [XLEN-1:0]  r_load_data;

    logic             w_accept;
    logic [1:0]       w_off;
    logic [4:0]       w_shamt;
    logic [SEL_W-1:0] w_sel;
    logic [XLEN-1:0]  w_shifted;
    logic [XLEN-1:0]  w_load_ext;

    assign w_accept = (i_mem_req.read | i_mem_req.write) & ~r_active;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_active <= 1'b0;
        end
        else if (w_accept)
        begin
            r_active <= 1'b1;
        end
        else if (i_ack)
        begin
            r_active <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_req <= i_mem_req;
        end
    end

    assign w_off   = r_req.addr[1:0];
    assign w_shamt = {w_off, 3'b000};

    // byte lanes of the access
    always_comb
    begin
        case (r_req.size)
            MEM_B, MEM_BU: w_sel = 4'b0001 << w_off;
            MEM_H, MEM_HU: w_sel = 4'b0011 << {w_off[1], 1'b0};
            default:       w_sel = 4'b1111;
        endcase
    end

    assign w_shifted = i_data >> w_shamt;

    always_comb
    begin
        case (r_req.size)
            MEM_B:   w_load_ext = {{24{w_shifted[7]}}, w_shifted[7:0]};
            MEM_H:   w_load_ext = {{16{w_shifted[15]}}, w_shifted[15:0]};
            MEM_BU:  w_load_ext = {24'd0, w_shifted[7:0]};
            MEM_HU:  w_load_ext = {16'd0, w_shifted[15:0]};
            default: w_load_ext = w_shifted;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_load_valid <= 1'b0;
        end
        else
        begin
            r_load_valid <= i_ack & r_req.read;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ack)
        begin
            r_load_data <= w_load_ext;
        end
    end

    assign o_req.adr = r_req.addr;
    assign o_req.dat = r_req.wdata << w_shamt;   // store data on its byte lanes
    assign o_req.we  = r_req.write;
    assign o_req.sel = w_sel;

    assign o_active     = r_active;
    assign o_load.valid = r_load_valid;
    assign o_load.data  = r_load_data;

endmodule

`default_nettype wire

/* source/rv_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_arbiter
(
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  rv_bus_pkg::bus_req_t         i_fetch_req,
    input  rv_bus_pkg::bus_req_t         i_lsu_req,
    input  logic                         i_lsu_active,
    input  logic                         i_wb_ack,
    output logic [rv_bus_pkg::XLEN-1:0]  o_wb_adr,
    output logic [rv_bus_pkg::XLEN-1:0]  o_wb_dat,
    output logic                         o_wb_we,
    output logic [rv_bus_pkg::SEL_W-1:0] o_wb_sel,
    output logic                         o_wb_stb,
    output logic                         o_wb_cyc,
    output logic                         o_fetch_ack,
    output logic                         o_lsu_ack
);

    import rv_bus_pkg::*;

    bus_req_t w_req;
    logic     r_stb_en;

    // strobe comes up one cycle after reset and stays
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_stb_en <= 1'b0;
        end
        else
        begin
            r_stb_en <= 1'b1;
        end
    end

    assign w_req = i_lsu_active ? i_lsu_req : i_fetch_req;   // data first

    assign o_wb_adr = w_req.adr;
    assign o_wb_dat = w_req.dat;
    assign o_wb_we  = i_lsu_active & i_lsu_req.we;
    assign o_wb_sel = w_req.sel;
    assign o_wb_stb = r_stb_en;
    assign o_wb_cyc = r_stb_en;

    assign o_fetch_ack = i_wb_ack & ~i_lsu_active;
    assign o_lsu_ack   = i_wb_ack & i_lsu_active;

endmodule

`default_nettype wire

/* source/rv_bus_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_frontend
#(
    parameter logic [rv_bus_pkg::XLEN-1:0] RESET_ADDR = '0
)
(
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_redirect,
    input  logic [rv_bus_pkg::XLEN-1:0]  i_redirect_pc,
    input  rv_bus_pkg::mem_req_t         i_mem_req,
    input  logic [rv_bus_pkg::XLEN-1:0]  i_wb_dat,
    input  logic                         i_wb_ack,
    output logic [rv_bus_pkg::XLEN-1:0]  o_wb_adr,
    output logic [rv_bus_pkg::XLEN-1:0]  o_wb_dat,
    output logic                         o_wb_we,
    output logic [rv_bus_pkg::SEL_W-1:0] o_wb_sel,
    output logic                         o_wb_stb,
    output logic                         o_wb_cyc,
    output rv_bus_pkg::fetch_t           o_instr,
    output rv_bus_pkg::load_t            o_load,
    output logic                         o_mem_busy
);

    import rv_bus_pkg::*;

    bus_req_t w_fetch_req;
    bus_req_t w_lsu_req;
    logic     w_lsu_active;
    logic     w_fetch_ack;
    logic     w_lsu_ack;

    rv_fetch
    #(
        .RESET_ADDR     (RESET_ADDR)
    )
    u_fetch
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_ack          (w_fetch_ack),
        .i_data         (i_wb_dat),
        .o_req          (w_fetch_req),
        .o_instr        (o_instr)
    );

    rv_lsu
    u_lsu
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_mem_req      (i_mem_req),
        .i_ack          (w_lsu_ack),
        .i_data         (i_wb_dat),
        .o_req          (w_lsu_req),
        .o_active       (w_lsu_active),
        .o_load         (o_load)
    );

    assign o_mem_busy = w_lsu_active;

    rv_bus_arbiter
    u_arbiter
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_fetch_req    (w_fetch_req),
        .i_lsu_req      (w_lsu_req),
        .i_lsu_active   (w_lsu_active),
        .i_wb_ack       (i_wb_ack),
        .o_wb_adr       (o_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_we        (o_wb_we),
        .o_wb_sel       (o_wb_sel),
        .o_wb_stb       (o_wb_stb),
        .o_wb_cyc       (o_wb_cyc),
        .o_fetch_ack    (w_fetch_ack),
        .o_lsu_ack      (w_lsu_ack)
    );

endmodule

`default_nettype wire

/* tb/rv_bus_frontend_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_frontend_chk
#(
    parameter logic [rv_bus_pkg::XLEN-1:0] RESET_ADDR = '0
)
(
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_redirect,
    input  logic [rv_bus_pkg::XLEN-1:0]  i_redirect_pc,
    input  rv_bus_pkg::mem_req_t         i_mem_req,
    input  logic                         i_wb_ack,
    input  logic [rv_bus_pkg::XLEN-1:0]  o_wb_adr,
    input  logic [rv_bus_pkg::XLEN-1:0]  o_wb_dat,
    input  logic                         o_wb_we,
    input  logic [rv_bus_pkg::SEL_W-1:0] o_wb_sel,
    input  logic                         o_wb_stb,
    input  logic                         o_wb_cyc,
    input  rv_bus_pkg::fetch_t           o_instr,
    input  rv_bus_pkg::load_t            o_load,
    input  logic                         o_mem_busy
);

    import rv_bus_pkg::*;

    int              fail_cnt = 0;
    logic [XLEN-1:2] r_exp_pc;
    mem_req_t        r_req;
    logic [XLEN-1:0] r_load_exp;
    logic [XLEN-1:0] shadow [16];   // 32'h1000 .. 32'h103f

    // 1, 2 or 4 lanes from the low size bits, moved up by the offset
    function automatic logic [SEL_W-1:0] lane_mask(input mem_size_e size, input logic [1:0] off);
        logic [SEL_W:0] ones;
        ones = (5'd1 << (5'd1 << size[1:0])) - 5'd1;
        return ones[SEL_W-1:0] << off;
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
                                                   input logic [1:0] off, input mem_size_e size);
        logic [XLEN-1:0] sh;
        sh = word >> (8 * off);
        case (size)
            MEM_B:   return XLEN'($signed(sh[7:0]));
            MEM_H:   return XLEN'($signed(sh[15:0]));
            MEM_BU:  return XLEN'(sh[7:0]);
            MEM_HU:  return XLEN'(sh[15:0]);
            default: return sh;
        endcase
    endfunction

    // next word address expected on o_instr
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_exp_pc <= RESET_ADDR[XLEN-1:2];
        else if (i_redirect)
            r_exp_pc <= i_redirect_pc[XLEN-1:2];
        else if (o_instr.valid)
            r_exp_pc <= o_instr.pc + 1'b1;
    end

    always @(posedge i_clk)
    begin
        if ((i_mem_req.read || i_mem_req.write) && !o_mem_busy)
            r_req <= i_mem_req;
        if (o_mem_busy && i_wb_ack)
        begin
            if (o_wb_we && o_wb_adr >= 32'h1000 && o_wb_adr < 32'h1040)
            begin
                for (int b = 0; b < SEL_W; b++)
                begin
                    if (o_wb_sel[b])
                        shadow[o_wb_adr[5:2]][8*b +: 8] <= o_wb_dat[8*b +: 8];
                end
            end
            if (r_req.read)
                r_load_exp <= load_value(shadow[o_wb_adr[5:2]], r_req.addr[1:0], r_req.size);
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk)
        !i_arst_n |-> !(o_wb_stb || o_wb_cyc || o_wb_we || o_instr.valid || o_load.valid))
    else
    begin
        fail_cnt++;
        $error("bus or valid outputs active while reset is held");
    end

    a_first_fetch: assert property (@(posedge i_clk) $rose(i_arst_n) |-> o_wb_adr == RESET_ADDR)
    else
    begin
        fail_cnt++;
        $error("Error first_fetch: expected %h, actual %h", RESET_ADDR, $sampled(o_wb_adr));
    end

    a_instr_word: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_instr.valid |-> o_instr.word == ~{o_instr.pc, 2'b00})
    else
    begin
        fail_cnt++;
        $error("Error instr_word: expected %h, actual %h",
               ~{$sampled(o_instr.pc), 2'b00}, $sampled(o_instr.word));
    end

    a_instr_seq: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_instr.valid |-> o_instr.pc == r_exp_pc)
    else
    begin
        fail_cnt++;
        $error("Error instr_pc: expected %h, actual %h",
               {$sampled(r_exp_pc), 2'b00}, {$sampled(o_instr.pc), 2'b00});
    end

    a_data_owner: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_busy |-> o_wb_adr == r_req.addr && o_wb_we == r_req.write)
    else
    begin
        fail_cnt++;
        $error("Error data_owner: expected adr/we %h/%b, actual %h/%b", $sampled(r_req.addr),
               $sampled(r_req.write), $sampled(o_wb_adr), $sampled(o_wb_we));
    end

    a_no_fetch: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_busy && i_wb_ack |=> !o_instr.valid)
    else
    begin
        fail_cnt++;
        $error("instruction delivered for a data acknowledge");
    end

    a_busy_start: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_mem_req.read || i_mem_req.write) && !o_mem_busy |=> o_mem_busy)
    else
    begin
        fail_cnt++;
        $error("accepted data request did not raise o_mem_busy");
    end

    // busy drops and a read delivers its data right after the data acknowledge
    a_access_end: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_busy && i_wb_ack |=> !o_mem_busy && o_load.valid == r_req.read)
    else
    begin
        fail_cnt++;
        $error("Error access_end: expected busy/valid 0/%b, actual %b/%b",
               $sampled(r_req.read), $sampled(o_mem_busy), $sampled(o_load.valid));
    end

    a_store_lanes: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_busy && r_req.write |-> o_wb_sel == lane_mask(r_req.size, r_req.addr[1:0])
            && o_wb_dat == r_req.wdata << {r_req.addr[1:0], 3'b000})
    else
    begin
        fail_cnt++;
        $error("Error store_lanes: expected sel/dat %b/%h, actual %b/%h",
               lane_mask($sampled(r_req.size), $sampled(r_req.addr[1:0])),
               $sampled(r_req.wdata) << {$sampled(r_req.addr[1:0]), 3'b000},
               $sampled(o_wb_sel), $sampled(o_wb_dat));
    end

    a_load_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_load.valid |-> o_load.data == r_load_exp)
    else
    begin
        fail_cnt++;
        $error("Error load_data: expected %h, actual %h", $sampled(r_load_exp),
               $sampled(o_load.data));
    end

endmodule

bind rv_bus_frontend rv_bus_frontend_chk #(.RESET_ADDR(RESET_ADDR)) u_chk (.*);

`default_nettype wire

/* tb/tb_rv_bus_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_bus_frontend;

    import rv_bus_pkg::*;

    localparam logic [XLEN-1:0] RESET_ADDR     = 32'h0000_0100;
    localparam logic [XLEN-1:0] RAM_BASE       = 32'h0000_1000;
    localparam int              TIMEOUT_CYCLES = 2000;   // about four times the sequence

    logic             clk;
    logic             arst_n;
    logic             redirect;
    logic [XLEN-1:0]  redirect_pc;
    mem_req_t         mem_req;
    logic [XLEN-1:0]  wb_dat;
    logic             wb_ack;
    logic [XLEN-1:0]  wb_adr;
    logic [XLEN-1:0]  wb_wdat;
    logic             wb_we;
    logic [SEL_W-1:0] wb_sel;
    logic             wb_stb;
    logic             wb_cyc;
    fetch_t           instr;
    load_t            load;
    logic             mem_busy;

    logic [XLEN-1:0]  ram [16];
    integer           seed      = 32'h58b4;
    int               wait_left = -1;
    int               cycles    = 0;
    int               n_instr   = 0;

    rv_bus_frontend #(.RESET_ADDR(RESET_ADDR)) dut
    (
        .i_clk(clk), .i_arst_n(arst_n), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_mem_req(mem_req), .i_wb_dat(wb_dat), .i_wb_ack(wb_ack),
        .o_wb_adr(wb_adr), .o_wb_dat(wb_wdat), .o_wb_we(wb_we), .o_wb_sel(wb_sel),
        .o_wb_stb(wb_stb), .o_wb_cyc(wb_cyc), .o_instr(instr), .o_load(load),
        .o_mem_busy(mem_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bus memory, ack after 0 to 3 idle cycles
    always @(negedge clk)
    begin
        wb_ack = 1'b0;
        if (wb_stb && wb_cyc)
        begin
            if (wait_left < 0)
                wait_left = $random(seed) & 3;
            if (wait_left == 0)
            begin
                wb_ack = 1'b1;
                wait_left = -1;
                if (wb_adr < RAM_BASE)
                    wb_dat = ~wb_adr;
                else if (wb_adr < RAM_BASE + 32'h40)
                    wb_dat = ram[wb_adr[5:2]];
                else
                    wb_dat = '0;
                for (int b = 0; b < SEL_W; b++)
                begin
                    if (wb_we && wb_sel[b] && wb_adr >= RAM_BASE && wb_adr < RAM_BASE + 32'h40)
                        ram[wb_adr[5:2]][8*b +: 8] = wb_wdat[8*b +: 8];
                end
            end
            else
                wait_left = wait_left - 1;
        end
    end

    always @(posedge clk)
    begin
        if (instr.valid)
            n_instr <= n_instr + 1;
    end

    always @(negedge clk)
    begin
        cycles = cycles + 1;
        if (dut.u_chk.fail_cnt != 0)
        begin
            $display("Testbench failed");
            $fatal(1, "an assertion in the bound checker failed");
        end
        else if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Testbench failed");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic wait_instrs(input int n);
        int target;
        target = n_instr + n;
        while (n_instr < target)
            @(negedge clk);
    endtask

    task automatic jump(input logic [XLEN-1:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    // one strobed access, returns once the unit is idle again
    task automatic mem_access(input logic rd, input mem_size_e size, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] wdata);
        while (mem_busy)
            @(negedge clk);
        mem_req = '{read: rd, write: ~rd, size: size, addr: addr, wdata: wdata};
        @(negedge clk);
        mem_req = '0;
        while (mem_busy)
            @(negedge clk);
    endtask

    initial
    begin
        mem_size_e sizes [5];
        int        step;
        sizes       = '{MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W};
        arst_n      = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        mem_req     = '0;
        wb_dat      = '0;
        wb_ack      = 1'b0;
        for (int i = 0; i < 16; i++)
            ram[i] = ~(RAM_BASE + 4 * i) ^ 32'h5a5a_0000;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        wait_instrs(8);
        jump(32'h0000_0800);
        wait_instrs(6);
        jump(32'h0000_0040);   // low enough that fetches stay below the RAM
        wait_instrs(6);

        for (int off = 0; off < 4; off++)
            mem_access(1'b0, MEM_B, RAM_BASE + off, $random(seed));
        for (int off = 0; off < 4; off += 2)
            mem_access(1'b0, MEM_H, RAM_BASE + 4 + off, $random(seed));
        mem_access(1'b0, MEM_W, RAM_BASE + 8, $random(seed));

        for (int w = 0; w < 3; w++)
        begin
            for (int s = 0; s < 5; s++)
            begin
                step = 1 << sizes[s][1:0];
                for (int off = 0; off < 4; off += step)
                    mem_access(1'b1, sizes[s], RAM_BASE + 4 * w + off, '0);
            end
        end

        repeat (3) @(negedge clk);
        if (dut.u_chk.fail_cnt == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("Testbench failed");
            $fatal(1, "the bound checker recorded assertion failures");
        end
    end

endmodule

`default_nettype wire

/* rv_bus_frontend.f */
source/rv_bus_pkg.sv
source/rv_fetch.sv
source/rv_lsu.sv
source/rv_bus_arbiter.sv
source/rv_bus_frontend.sv
tb/rv_bus_frontend_chk.sv
tb/tb_rv_bus_frontend.sv

/* Bender.yml */
package:
  name: rv_bus_frontend

sources:
  - source/rv_bus_pkg.sv
  - source/rv_fetch.sv
  - source/rv_lsu.sv
  - source/rv_bus_arbiter.sv
  - source/rv_bus_frontend.sv
  - target: simulation
    files:
      - tb/rv_bus_frontend_chk.sv
      - tb/tb_rv_bus_frontend.sv
